//--- hw/arch_pkg.sv
package arch_pkg;

    localparam int xlen = 32;
    localparam int seg_w = 16;
    localparam int num_regs = 8;

    typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

    // low bits carry the exception cause, bit 3 flags an external interrupt
    typedef enum logic [3:0] {
        ie_none      = 4'h0,
        ie_fault     = 4'h1,
        ie_trap      = 4'h2,
        ie_interrupt = 4'h8
    } ie_type_e;

endpackage

//--- hw/wb_types_pkg.sv
package wb_types_pkg;

    typedef enum logic [1:0] {
        kind_none,
        kind_reg,
        kind_seg,
        kind_mem
    } slot_kind_e;

    typedef enum logic [1:0] {
        op_normal,
        op_branch,
        op_far_jmp,   // slot 0 = new eip, slot 1 = cs
        op_halt
    } wb_op_e;

    typedef struct packed {
        slot_kind_e                 kind;
        logic                       wb;
        arch_pkg::reg_idx_t         dest;
        logic [arch_pkg::xlen-1:0]  addr;   // store address, mem slots only
        logic [arch_pkg::xlen-1:0]  data;
    } wb_slot_t;

    typedef struct packed {
        logic                       valid;
        wb_op_e                     op;
        logic [arch_pkg::xlen-1:0]  eip_next;
        logic                       br_valid;
        logic                       br_taken;
        logic                       br_correct;
        logic [arch_pkg::xlen-1:0]  br_target;
        logic                       exc;
        arch_pkg::ie_type_e         exc_type;
        logic                       idtr_orig;
        wb_slot_t [3:0]             slots;
    } wb_bundle_t;

    typedef struct packed {
        logic [arch_pkg::xlen-1:0]  addr;
        logic [arch_pkg::xlen-1:0]  data;
    } store_req_t;

    typedef struct packed {
        logic                       en;
        arch_pkg::reg_idx_t         idx;
        logic [arch_pkg::xlen-1:0]  data;
    } reg_wr_t;

endpackage

//--- hw/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage #(
    parameter int num_slots = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  wb_types_pkg::wb_bundle_t               in_bundle,
    input  logic                                   interrupt,
    input  logic                                   idtr_busy,
    input  logic                                   intr_en,
    input  logic                                   halt_clr,
    input  logic                                   full,
    output wb_types_pkg::reg_wr_t [num_slots-1:0]  reg_wr,
    output wb_types_pkg::reg_wr_t [num_slots-1:0]  seg_wr,
    output logic                                   st_push,
    output wb_types_pkg::store_req_t               st_req,
    output logic                                   stall,
    output logic                                   valid_out,
    output logic                                   resteer,
    output logic [arch_pkg::xlen-1:0]              new_eip,
    output logic [arch_pkg::xlen-1:0]              fip_even,
    output logic [arch_pkg::xlen-1:0]              fip_odd,
    output logic                                   ie_valid,
    output arch_pkg::ie_type_e                     ie_type,
    output logic                                   halt
);
    import arch_pkg::*;
    import wb_types_pkg::*;

    logic [num_slots-1:0] mem_hit;
    logic                 store_wanted;
    logic                 intr_q;
    logic                 ie_hit;
    logic                 far_jmp;
    logic [xlen-1:0]      target;
    logic [xlen-1:0]      line;
    logic [xlen-1:0]      line_nxt;
    logic                 halt_set;

    // mem slots before valid_out, needed for stall
    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            mem_hit[i] = (in_bundle.slots[i].kind == kind_mem) && in_bundle.slots[i].wb;
        end
    end

    assign store_wanted = in_bundle.valid && (|mem_hit);
    assign stall        = store_wanted && full;
    assign intr_q       = interrupt && intr_en;
    assign ie_hit       = in_bundle.exc || intr_q;

    // idtr origin retires even through an event
    assign valid_out = in_bundle.valid &&
                       ((!stall && !ie_hit) || in_bundle.idtr_orig);

    // walk downwards so the lowest mem slot is the one left standing
    always_comb begin
        st_push = 1'b0;
        st_req  = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            reg_wr[i] = '{en:   valid_out && in_bundle.slots[i].wb &&
                                (in_bundle.slots[i].kind == kind_reg),
                          idx:  in_bundle.slots[i].dest,
                          data: in_bundle.slots[i].data};
            seg_wr[i] = '{en:   valid_out && in_bundle.slots[i].wb &&
                                (in_bundle.slots[i].kind == kind_seg),
                          idx:  in_bundle.slots[i].dest,
                          data: in_bundle.slots[i].data};
            if (valid_out && mem_hit[i]) begin
                st_push     = 1'b1;
                st_req.addr = in_bundle.slots[i].addr;
                st_req.data = in_bundle.slots[i].data;
            end
        end
    end

    assign far_jmp = in_bundle.op == op_far_jmp;
    assign target  = far_jmp ? in_bundle.slots[0].data : in_bundle.br_target;
    assign new_eip = (in_bundle.br_taken || far_jmp) ? target : in_bundle.eip_next;

    // fetch works on 16-byte lines, even/odd banks by bit 4
    assign line     = {target[xlen-1:4], 4'h0};
    assign line_nxt = line + xlen'(16);
    assign fip_even = target[4] ? line_nxt : line;
    assign fip_odd  = target[4] ? line : line_nxt;

    assign resteer = valid_out && in_bundle.br_valid && !in_bundle.br_correct;

    assign ie_valid = in_bundle.valid && ie_hit && !idtr_busy;
    assign ie_type  = ie_valid ?
                      ie_type_e'({intr_q, in_bundle.exc ? in_bundle.exc_type[2:0] : 3'b000}) :
                      ie_none;

    assign halt_set = valid_out && (in_bundle.op == op_halt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt <= 1'b0;
        end else if (halt_set) begin
            halt <= 1'b1;   // newer halt beats a pending clear
        end else if (halt_clr) begin
            halt <= 1'b0;
        end
    end

endmodule

//--- hw/arch_reg_files.sv
`timescale 1ns/1ps

module arch_reg_files #(
    parameter int num_slots = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  wb_types_pkg::reg_wr_t [num_slots-1:0]  reg_wr,
    input  wb_types_pkg::reg_wr_t [num_slots-1:0]  seg_wr,
    input  arch_pkg::reg_idx_t                     rd_idx,
    output logic [arch_pkg::xlen-1:0]              rd_data,
    input  arch_pkg::reg_idx_t                     seg_rd_idx,
    output logic [arch_pkg::seg_w-1:0]             seg_rd_data
);
    import arch_pkg::*;

    logic [xlen-1:0]  gpr [num_regs];
    logic [seg_w-1:0] sel [num_regs];

    // later slot overrides an earlier one on the same index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpr <= '{default: '0};
            sel <= '{default: '0};
        end else begin
            for (int i = 0; i < num_slots; i++) begin
                if (reg_wr[i].en) begin
                    gpr[reg_wr[i].idx] <= reg_wr[i].data;
                end
                if (seg_wr[i].en) begin
                    sel[seg_wr[i].idx] <= seg_wr[i].data[seg_w-1:0];  // selector is low half
                end
            end
        end
    end

    assign rd_data     = gpr[rd_idx];
    assign seg_rd_data = sel[seg_rd_idx];

endmodule

//--- hw/store_queue.sv
`timescale 1ns/1ps

module store_queue #(
    parameter int queue_depth = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  wb_types_pkg::store_req_t push_req,
    output logic                     full,
    output logic                     mem_valid,
    output wb_types_pkg::store_req_t mem_req,
    input  logic                     mem_ready
);
    import wb_types_pkg::*;

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    store_req_t       mem [queue_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        ptr_inc = (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = count == cnt_w'(queue_depth);
    assign mem_valid = count != '0;
    assign mem_req   = mem[rd_ptr];
    assign do_push   = push && !full;   // stage stalls before this matters
    assign do_pop    = mem_valid && mem_ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/wb_ctrl_regs.sv
`timescale 1ns/1ps

module wb_ctrl_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        retire_pulse,
    input  logic        resteer,
    input  logic        halt,
    output logic        intr_en,
    output logic        halt_clr
);
    localparam logic [3:0] addr_ctrl     = 4'h0;
    localparam logic [3:0] addr_status   = 4'h4;
    localparam logic [3:0] addr_retired  = 4'h8;
    localparam logic [3:0] addr_resteers = 4'hc;

    logic        access;
    logic        mapped;
    logic        wr_ctrl;
    logic [31:0] retired;
    logic [31:0] resteers;

    assign access  = psel && penable;
    assign mapped  = paddr[1:0] == 2'b00;   // four word slots fill the space
    assign pready  = access;                // no wait states
    assign pslverr = access && !mapped;
    assign wr_ctrl = access && pwrite && (paddr == addr_ctrl);

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                addr_ctrl:     prdata = {31'b0, intr_en};  // halt clear reads 0
                addr_status:   prdata = {31'b0, halt};
                addr_retired:  prdata = retired;
                addr_resteers: prdata = resteers;
                default:       prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_en  <= 1'b0;
            halt_clr <= 1'b0;
        end else begin
            halt_clr <= wr_ctrl && pwdata[1];  // one cycle pulse
            if (wr_ctrl) intr_en <= pwdata[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired  <= '0;
            resteers <= '0;
        end else begin
            if (retire_pulse) retired <= retired + 1'b1;
            if (resteer) resteers <= resteers + 1'b1;
        end
    end

endmodule

//--- hw/wb_top.sv
`timescale 1ns/1ps

module wb_top #(
    parameter int num_slots   = 4,
    parameter int queue_depth = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  wb_types_pkg::wb_bundle_t    in_bundle,
    input  logic                        interrupt,
    input  logic                        idtr_busy,
    output logic                        stall,
    output logic                        valid_out,
    output logic                        resteer,
    output logic [arch_pkg::xlen-1:0]   new_eip,
    output logic [arch_pkg::xlen-1:0]   fip_even,
    output logic [arch_pkg::xlen-1:0]   fip_odd,
    output logic                        ie_valid,
    output arch_pkg::ie_type_e          ie_type,
    output logic                        halt,
    input  arch_pkg::reg_idx_t          rd_idx,
    output logic [arch_pkg::xlen-1:0]   rd_data,
    input  arch_pkg::reg_idx_t          seg_rd_idx,
    output logic [arch_pkg::seg_w-1:0]  seg_rd_data,
    output logic                        mem_valid,
    output wb_types_pkg::store_req_t    mem_req,
    input  logic                        mem_ready,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [3:0]                  paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr
);
    import wb_types_pkg::*;

    reg_wr_t [num_slots-1:0] reg_wr;
    reg_wr_t [num_slots-1:0] seg_wr;
    store_req_t              st_req;
    logic                    st_push;
    logic                    full;
    logic                    intr_en;
    logic                    halt_clr;

    writeback_stage #(.num_slots(num_slots)) u_stage (
        .clk, .rst_n, .in_bundle, .interrupt, .idtr_busy, .intr_en, .halt_clr, .full,
        .reg_wr, .seg_wr, .st_push, .st_req, .stall, .valid_out, .resteer,
        .new_eip, .fip_even, .fip_odd, .ie_valid, .ie_type, .halt
    );

    arch_reg_files #(.num_slots(num_slots)) u_regs (
        .clk, .rst_n, .reg_wr, .seg_wr, .rd_idx, .rd_data, .seg_rd_idx, .seg_rd_data
    );

    store_queue #(.queue_depth(queue_depth)) u_queue (
        .clk, .rst_n, .push(st_push), .push_req(st_req), .full,
        .mem_valid, .mem_req, .mem_ready
    );

    wb_ctrl_regs u_ctrl (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .retire_pulse(valid_out), .resteer, .halt, .intr_en, .halt_clr
    );

endmodule

//--- bench/wb_assert.sv
`timescale 1ns/1ps

module wb_checks (
    input logic                     clk,
    input logic                     rst_n,
    input wb_types_pkg::wb_bundle_t in_bundle,
    input logic                     full,
    input logic                     stall,
    input logic                     valid_out,
    input logic                     resteer,
    input logic                     ie_valid,
    input arch_pkg::ie_type_e       ie_type,
    input logic                     halt,
    input logic                     mem_valid,
    input wb_types_pkg::store_req_t mem_req,
    input logic                     mem_ready,
    input logic                     psel,
    input logic                     penable,
    input logic                     pslverr
);
    import arch_pkg::*;
    import wb_types_pkg::*;

    int   fails = 0;
    logic store_wanted;

    always_comb begin
        store_wanted = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (in_bundle.slots[i].kind == kind_mem && in_bundle.slots[i].wb) store_wanted = 1'b1;
        end
        store_wanted = store_wanted && in_bundle.valid;
    end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall == (store_wanted && full))
        else begin $error("stall differs from store_wanted and full"); fails++; end

    a_resteer: assert property (@(posedge clk) disable iff (!rst_n)
        resteer |-> valid_out && in_bundle.br_valid && !in_bundle.br_correct)
        else begin $error("resteer without a retiring mispredicted branch"); fails++; end

    a_ie_type: assert property (@(posedge clk) disable iff (!rst_n)
        !ie_valid |-> ie_type == ie_none)
        else begin $error("ie_type nonzero while ie_valid is low"); fails++; end

    a_exc: assert property (@(posedge clk) disable iff (!rst_n)
        in_bundle.valid && in_bundle.exc && !in_bundle.idtr_orig |-> !valid_out)
        else begin $error("exception bundle retired"); fails++; end

    a_halt: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && in_bundle.op == op_halt |=> halt)
        else begin $error("halt not set after a halt bundle"); fails++; end

    // held request under back-pressure
    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
        else begin $error("store request dropped or changed while stalled"); fails++; end

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> psel && penable)
        else begin $error("pslverr outside the APB access phase"); fails++; end

endmodule

bind wb_top wb_checks u_checks (.*);

//--- bench/tb_wb_top.sv
`timescale 1ns/1ps

module tb_wb_top;
    import arch_pkg::*;
    import wb_types_pkg::*;

    localparam int n_reg_tests    = 40;
    localparam int n_store_tests  = 24;
    localparam int timeout_cycles = 4 * (16 + 4 * n_reg_tests + 12 * n_store_tests + 60);

    logic             clk = 1'b0;
    logic             rst_n;
    wb_bundle_t       in_bundle;
    logic             interrupt, idtr_busy, mem_ready;
    logic             stall, valid_out, resteer, ie_valid, halt, mem_valid;
    logic [31:0]      new_eip, fip_even, fip_odd, rd_data, pwdata, prdata;
    ie_type_e         ie_type;
    reg_idx_t         rd_idx, seg_rd_idx;
    logic [15:0]      seg_rd_data;
    store_req_t       mem_req;
    logic             psel, penable, pwrite, pready, pslverr;
    logic [3:0]       paddr;

    logic [31:0]      lfsr;
    logic [31:0]      gpr_m [8];
    logic [15:0]      seg_m [8];
    store_req_t       exp_q [$];
    logic             intr_en_m = 1'b0;
    logic             bp_on = 1'b0;
    int               errors = 0;
    int               cycles = 0;
    int               retired_m = 0;
    int               resteer_m = 0;

    wb_top #(.num_slots(4), .queue_depth(4)) dut0 (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // taps 32 22 2 1
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        if (bp_on) mem_ready <= (take_bits(3) == 3'b000);  // mostly stalled memory
    endtask

    function automatic wb_bundle_t rand_bundle(input logic allow_mem);
        wb_bundle_t b;
        b = '0;
        b.valid = 1'b1;
        b.eip_next = take_bits(32);
        for (int i = 0; i < 4; i++) begin
            b.slots[i].kind = slot_kind_e'(take_bits(2));
            if (!allow_mem && b.slots[i].kind == kind_mem) b.slots[i].kind = kind_reg;
            b.slots[i].wb = take_bits(2) != 2'b00;
            b.slots[i].dest = take_bits(3);
            b.slots[i].addr = take_bits(30) << 2;
            b.slots[i].data = take_bits(32);
        end
        return b;
    endfunction

    task automatic send(input wb_bundle_t b, input logic intr, input logic busy);
        logic        ev, exp_vo, exp_ie, mem_found;
        logic [31:0] tgt, line, exp_type;
        reg_idx_t    ri;
        next_edge();
        in_bundle <= b;
        interrupt <= intr;
        idtr_busy <= busy;
        @(negedge clk);
        while (stall) begin
            next_edge();
            @(negedge clk);
        end
        ev = b.exc || (intr && intr_en_m);
        exp_vo = b.valid && (!ev || b.idtr_orig);
        exp_ie = b.valid && ev && !busy;
        exp_type = (b.exc ? 32'(b.exc_type) : 32'h0) | ((intr && intr_en_m) ? 32'h8 : 32'h0);
        tgt = (b.op == op_far_jmp) ? b.slots[0].data : b.br_target;
        line = tgt & ~32'hf;
        check_eq("valid_out", valid_out, exp_vo);
        check_eq("new_eip", new_eip, (b.br_taken || b.op == op_far_jmp) ? tgt : b.eip_next);
        check_eq("fip_even", fip_even, line[4] ? line + 32'd16 : line);
        check_eq("fip_odd", fip_odd, line[4] ? line : line + 32'd16);
        check_eq("resteer", resteer, exp_vo && b.br_valid && !b.br_correct);
        check_eq("ie_valid", ie_valid, exp_ie);
        check_eq("ie_type", ie_type, exp_ie ? exp_type : 32'h0);
        if (exp_vo) begin
            retired_m++;
            resteer_m += (b.br_valid && !b.br_correct);
            mem_found = 1'b0;
            for (int i = 0; i < 4; i++) begin
                if (b.slots[i].wb && b.slots[i].kind == kind_reg)
                    gpr_m[b.slots[i].dest] = b.slots[i].data;
                if (b.slots[i].wb && b.slots[i].kind == kind_seg)
                    seg_m[b.slots[i].dest] = b.slots[i].data[15:0];
                if (b.slots[i].wb && b.slots[i].kind == kind_mem && !mem_found) begin
                    exp_q.push_back('{addr: b.slots[i].addr, data: b.slots[i].data});
                    mem_found = 1'b1;
                end
            end
        end
        ri = b.slots[take_bits(2)].dest;
        next_edge();
        in_bundle <= '0;
        interrupt <= 1'b0;
        idtr_busy <= 1'b0;
        rd_idx <= ri;
        seg_rd_idx <= ri;
        @(negedge clk);
        check_eq("rd_data", rd_data, gpr_m[ri]);
        check_eq("seg_rd_data", seg_rd_data, seg_m[ri]);
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        next_edge();
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdata;
        next_edge();
        penable <= 1'b1;
        @(negedge clk);
        if (!pready) begin
            errors++;
            $display("APB access phase at %0t ns came without pready", $time);
        end
        rdata = prdata;
        err = pslverr;
        next_edge();
        psel <= 1'b0;
        penable <= 1'b0;
        if (wr && addr == 4'h0) intr_en_m = wdata[0];
    endtask

    // store order checked where the transfer is stable
    always @(negedge clk) begin
        if (rst_n && mem_valid && mem_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("store request at %0t ns when no store was expected", $time);
            end else begin
                check_eq("mem_req.addr", mem_req.addr, exp_q[0].addr);
                check_eq("mem_req.data", mem_req.data, exp_q[0].data);
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, the tests did not complete", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] rdata;
        logic        err;
        wb_bundle_t  b;
        lfsr = 32'h79d1_06dd;
        gpr_m = '{default: '0};
        seg_m = '{default: '0};
        rst_n = 1'b0;
        in_bundle = '0;
        interrupt = 1'b0;
        idtr_busy = 1'b0;
        mem_ready = 1'b1;
        rd_idx = '0;
        seg_rd_idx = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        repeat (n_reg_tests) send(rand_bundle(1'b0), 1'b0, 1'b0);
        b = rand_bundle(1'b0);
        b.valid = 1'b0;   // must write nothing
        send(b, 1'b0, 1'b0);

        bp_on = 1'b1;
        repeat (n_store_tests) send(rand_bundle(1'b1), 1'b0, 1'b0);
        bp_on = 1'b0;
        next_edge();
        mem_ready <= 1'b1;
        while (exp_q.size() != 0) next_edge();
        @(negedge clk);
        check_eq("mem_valid", mem_valid, 1'b0);

        repeat (12) begin
            b = rand_bundle(1'b0);
            b.op = op_branch;
            b.br_valid = 1'b1;
            b.br_taken = take_bits(1);
            b.br_correct = take_bits(1);
            b.br_target = take_bits(32);
            send(b, 1'b0, 1'b0);
        end
        b = rand_bundle(1'b0);
        b.op = op_far_jmp;
        b.slots[0].kind = kind_none;
        b.slots[1].kind = kind_seg;   // cs
        b.slots[1].wb = 1'b1;
        b.slots[1].dest = 3'd1;
        send(b, 1'b0, 1'b0);

        b = rand_bundle(1'b0);
        b.exc = 1'b1;
        b.exc_type = ie_fault;
        send(b, 1'b0, 1'b0);
        b.idtr_orig = 1'b1;
        send(b, 1'b0, 1'b0);
        send(rand_bundle(1'b0), 1'b1, 1'b0);   // masked interrupt
        apb_xfer(1'b1, 4'h0, 32'h1, rdata, err);
        send(rand_bundle(1'b0), 1'b1, 1'b0);
        send(rand_bundle(1'b0), 1'b1, 1'b1);
        b.exc_type = ie_trap;
        send(b, 1'b1, 1'b0);
        apb_xfer(1'b1, 4'h0, 32'h0, rdata, err);

        b = rand_bundle(1'b0);
        b.op = op_halt;
        send(b, 1'b0, 1'b0);
        apb_xfer(1'b0, 4'h4, 32'h0, rdata, err);
        check_eq("STATUS.halt", rdata[0], 1'b1);
        check_eq("pslverr", err, 1'b0);
        apb_xfer(1'b1, 4'h0, 32'h2, rdata, err);
        apb_xfer(1'b0, 4'h4, 32'h0, rdata, err);
        check_eq("STATUS.halt", rdata[0], 1'b0);
        apb_xfer(1'b0, 4'h0, 32'h0, rdata, err);
        check_eq("CTRL", rdata, 32'h0);
        apb_xfer(1'b1, 4'h8, 32'hffff, rdata, err);   // read-only, no error
        check_eq("pslverr", err, 1'b0);
        apb_xfer(1'b0, 4'h8, 32'h0, rdata, err);
        check_eq("RETIRED", rdata, retired_m);
        apb_xfer(1'b0, 4'hc, 32'h0, rdata, err);
        check_eq("RESTEERS", rdata, resteer_m);
        apb_xfer(1'b0, 4'h6, 32'h0, rdata, err);
        check_eq("pslverr", err, 1'b1);

        next_edge();
        $display("errors: %0d value mismatches, %0d assertion failures",
                 errors, dut0.u_checks.fails);
        if (errors == 0 && dut0.u_checks.fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/arch_pkg.sv
hw/wb_types_pkg.sv
hw/writeback_stage.sv
hw/arch_reg_files.sv
hw/store_queue.sv
hw/wb_ctrl_regs.sv
hw/wb_top.sv
bench/wb_assert.sv
bench/tb_wb_top.sv

//--- Bender.yml
package:
  name: wb_stage

sources:
  - hw/arch_pkg.sv
  - hw/wb_types_pkg.sv
  - hw/writeback_stage.sv
  - hw/arch_reg_files.sv
  - hw/store_queue.sv
  - hw/wb_ctrl_regs.sv
  - hw/wb_top.sv
  - target: test
    files:
      - bench/wb_assert.sv
      - bench/tb_wb_top.sv
